/* all.f */
verilog/core_pkg.sv
verilog/cycle_counter.sv
verilog/core_fsm.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/ex_stage.sv
verilog/core_top.sv
dv/tb_checker.sv
dv/tb_top.sv

/* dv/tb_checker.sv */
// retire checker and reference model
module tb_checker import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input logic            clk,
  input logic [xlen-1:0] imem_addr,
  input mem_req_t        mem_out,
  input retire_t         retire_out,
  input logic            halted
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [xlen-1:0] xreg [32];
  logic [xlen-1:0] ram_m [64];
  logic [xlen-1:0] pc_m;
  mem_req_t        exp_mem;
  logic            halt_m;
  int              errors;
  int              n_pass;
  int              n_fail;

  initial begin
    for (int k = 0; k < 32; k++) begin
      xreg[5'(k)] = '0;
    end
    errors = 0;
    n_pass = 0;
    n_fail = 0;
  end

  // one instruction of the isa on the shadow state
  function automatic retire_t model_step();
    logic [31:0]     ins;
    logic [4:0]      opc;
    logic [2:0]      f3;
    logic [xlen-1:0] a;
    logic [xlen-1:0] bv;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] next;
    logic [xlen-1:0] mask;
    retire_t         e;
    ins   = tb_top.rom[pc_m[9:2]];
    opc   = ins[6:2];
    f3    = ins[14:12];
    a     = xreg[ins[19:15]];
    bv    = xreg[ins[24:20]];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = {{32{ins[31]}}, ins[31:12], 12'h000};
    imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    e       = '0;
    e.valid = 1'b1;
    e.pc    = pc_m;
    e.rd    = ins[11:7];
    exp_mem = '0;
    next    = pc_m + 64'd4;
    case (opc)
      opc_lui:   {e.rd_wen, e.data} = {1'b1, imm_u};
      opc_auipc: {e.rd_wen, e.data} = {1'b1, pc_m + imm_u};
      opc_addi:  {e.rd_wen, e.data} = {1'b1, a + imm_i};
      opc_add:   {e.rd_wen, e.data} = {1'b1, a + bv};
      opc_jal: begin
        {e.rd_wen, e.data} = {1'b1, pc_m + 64'd4};
        next = pc_m + imm_j;
      end
      opc_jalr: begin
        {e.rd_wen, e.data} = {1'b1, pc_m + 64'd4};
        next = (a + imm_i) & ~64'd1;
      end
      opc_beq: begin
        if (a == bv) next = pc_m + imm_b;
      end
      opc_load: begin
        exp_mem.ren  = 1'b1;
        exp_mem.addr = a + imm_i;
        {e.rd_wen, e.data} = {1'b1, ram_m[exp_mem.addr[8:3]]};
      end
      opc_store: begin
        case (f3)
          funct3_sb: mask = 64'hff;
          funct3_sh: mask = 64'hffff;
          funct3_sw: mask = 64'hffff_ffff;
          default:   mask = '1;
        endcase
        exp_mem.wen   = 1'b1;
        exp_mem.addr  = a + imm_s;
        exp_mem.wdata = bv;
        exp_mem.wmask = mask;
        ram_m[exp_mem.addr[8:3]] = (ram_m[exp_mem.addr[8:3]] & ~mask) | (bv & mask);
      end
      opc_env: halt_m = 1'b1;
      default: ;
    endcase
    if (e.rd_wen && e.rd != 5'd0) xreg[e.rd] = e.data;
    pc_m = next;
    return e;
  endfunction

  task automatic compare(string name, string what, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  // core must sit still through reset and until start
  task automatic check_quiet(string name, int n);
    for (int k = 0; k < n; k++) begin
      @(negedge clk);
      compare(name, "idle retire valid", 64'd0, 64'(retire_out.valid));
      compare(name, "idle mem_ren", 64'd0, 64'(mem_out.ren));
      compare(name, "idle mem_wen", 64'd0, 64'(mem_out.wen));
      compare(name, "idle halted", 64'd0, 64'(halted));
      compare(name, "idle imem_addr", reset_pc, imem_addr);
    end
  endtask

  task automatic check_program(string name);
    retire_t exp;
    int      cyc;
    int      gap;
    int      n;
    logic    timed_out;
    pc_m      = reset_pc;
    halt_m    = 1'b0;
    timed_out = 1'b0;
    gap       = 7;
    n         = 0;
    for (int k = 0; k < 64; k++) begin
      ram_m[6'(k)] = tb_top.ram[6'(k)];
    end
    while (!halt_m && n < 64 && !timed_out) begin
      exp = model_step();
      n++;
      cyc = 0;
      do begin
        @(negedge clk);
        cyc++;
      end while (!retire_out.valid && cyc < 200);
      if (!retire_out.valid) begin
        $display("test %s: retire of pc %h never came", name, exp.pc);
        errors++;
        timed_out = 1'b1;
      end else begin
        compare(name, "retire gap", 64'(gap), 64'(cyc));
        gap = 6;
        compare(name, "halted at retire", 64'd0, 64'(halted));
        compare(name, "pc", exp.pc, retire_out.pc);
        compare(name, "rd_wen", 64'(exp.rd_wen), 64'(retire_out.rd_wen));
        if (exp.rd_wen) begin
          compare(name, "rd", 64'(exp.rd), 64'(retire_out.rd));
          compare(name, "data", exp.data, retire_out.data);
        end
        compare(name, "mem_wen", 64'(exp_mem.wen), 64'(mem_out.wen));
        compare(name, "mem_ren", 64'(exp_mem.ren), 64'(mem_out.ren));
        if (exp_mem.wen || exp_mem.ren) compare(name, "mem addr", exp_mem.addr, mem_out.addr);
        if (exp_mem.wen) begin
          compare(name, "mem wdata", exp_mem.wdata, mem_out.wdata);
          compare(name, "mem wmask", exp_mem.wmask, mem_out.wmask);
        end
      end
    end
    if (!timed_out && !halt_m) begin
      $display("test %s: no ecall within 64 instructions", name);
      errors++;
    end else if (!timed_out) begin
      @(negedge clk);
      if (!halted) begin
        $display("test %s: halted did not rise one cycle after ecall", name);
        errors++;
      end
      for (int k = 0; k < 50; k++) begin
        @(negedge clk);
        if (retire_out.valid) begin
          $display("test %s: instruction retired after halt", name);
          errors++;
        end
      end
    end
    if (errors == 0) begin
      n_pass++;
      $display("test %s: passed, %0d instructions", name, n);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors);
    end
    errors = 0;
  endtask

endmodule

/* dv/tb_top.sv */
// core testbench top
module tb_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [xlen-1:0] reset_pc = '0;

  logic            clk;
  logic            rst;
  logic            start;
  logic [xlen-1:0] imem_addr;
  logic [31:0]     imem_rdata;
  mem_req_t        mem_out;
  logic [xlen-1:0] mem_rdata;
  retire_t         retire_out;
  logic            halted;
  logic [31:0]     rom [256];
  logic [xlen-1:0] ram [64];
  logic [31:0]     lfsr;
  int              n_inst;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign imem_rdata = rom[imem_addr[9:2]];
  assign mem_rdata  = ram[mem_out.addr[8:3]];

  // ram refills while in reset, stores merge under the mask
  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < 64; k++) begin
        ram[6'(k)] <= {8{2'b10, 6'(k)}};
      end
    end else if (mem_out.wen) begin
      ram[mem_out.addr[8:3]] <= (ram[mem_out.addr[8:3]] & ~mem_out.wmask)
                                | (mem_out.wdata & mem_out.wmask);
    end
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(32'd1 + rand_bits(3) % 32'd7);
  endfunction

  function automatic logic [31:0] enc_i(logic [4:0] opc, logic [4:0] rd, logic [2:0] f3,
                                        logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_r(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {7'b0, rs2, rs1, 3'b000, rd, opc_add, 2'b11};
  endfunction

  function automatic logic [31:0] enc_s(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store, 2'b11};
  endfunction

  function automatic logic [31:0] enc_b(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opc_beq, 2'b11};
  endfunction

  function automatic logic [31:0] enc_u(logic [4:0] opc, logic [4:0] rd, logic [19:0] imm);
    return {imm, rd, opc, 2'b11};
  endfunction

  function automatic logic [31:0] enc_j(logic [4:0] rd, logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal, 2'b11};
  endfunction

  // unused words hold ecall so a stray pc still halts
  task automatic new_program();
    for (int k = 0; k < 256; k++) begin
      rom[8'(k)] = enc_i(opc_env, 5'd0, 3'd0, 5'd0, 12'd0);
    end
    n_inst = 0;
  endtask

  task automatic emit(logic [31:0] w);
    rom[8'(n_inst)] = w;
    n_inst++;
  endtask

  task automatic init_regs();
    for (int k = 1; k < 8; k++) begin
      emit(enc_u(opc_lui, 5'(k), 20'(rand_bits(20))));
      emit(enc_i(opc_addi, 5'(k), 3'd0, 5'(k), 12'(rand_bits(12))));
    end
  endtask

  task automatic run_test(string name);
    @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    chk_i.check_quiet(name, 1);
    @(posedge clk);
    rst <= 1'b0;
    chk_i.check_quiet(name, 3);
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    chk_i.check_program(name);
  endtask

  initial begin
    logic [11:0] off;
    rst   = 1'b1;
    start = 1'b0;
    lfsr  = 32'd17;

    new_program();
    init_regs();
    for (int k = 0; k < 20; k++) begin
      case (rand_bits(2))
        32'd0: emit(enc_i(opc_addi, rand_reg(), 3'd0, rand_reg(), 12'(rand_bits(12))));
        32'd1: emit(enc_r(rand_reg(), rand_reg(), rand_reg()));
        32'd2: emit(enc_u(opc_lui, rand_reg(), 20'(rand_bits(20))));
        default: emit(enc_u(opc_auipc, rand_reg(), 20'(rand_bits(20))));
      endcase
    end
    run_test("arith");

    new_program();
    init_regs();
    for (int k = 0; k < 8; k++) begin
      off = {3'b000, 6'(rand_bits(6)), 3'b000};
      emit(enc_s(3'(k % 4), 5'd0, rand_reg(), off));
      emit(enc_i(opc_load, rand_reg(), 3'b011, 5'd0, off));
    end
    run_test("mem");

    // taken beq, untaken beq, jal, jalr with bit 0 set in the target
    new_program();
    emit(enc_i(opc_addi, 5'd1, 3'd0, 5'd0, 12'd5));
    emit(enc_i(opc_addi, 5'd2, 3'd0, 5'd0, 12'd5));
    emit(enc_b(5'd1, 5'd2, 13'd8));
    emit(enc_i(opc_addi, 5'd3, 3'd0, 5'd0, 12'd1));
    emit(enc_b(5'd1, 5'd0, 13'd8));
    emit(enc_j(5'd4, 21'd8));
    emit(enc_i(opc_addi, 5'd3, 3'd0, 5'd0, 12'd2));
    emit(enc_i(opc_addi, 5'd5, 3'd0, 5'd0, 12'd45));
    emit(enc_i(opc_jalr, 5'd6, 3'd0, 5'd5, 12'd0));
    emit(enc_i(opc_addi, 5'd3, 3'd0, 5'd0, 12'd3));
    emit(enc_i(opc_addi, 5'd3, 3'd0, 5'd0, 12'd4));
    emit(enc_r(5'd7, 5'd4, 5'd6));
    run_test("control");

    new_program();
    init_regs();
    emit(enc_i(opc_addi, 5'd0, 3'd0, 5'd0, 12'(rand_bits(12))));
    emit(enc_u(opc_lui, 5'd0, 20'(rand_bits(20))));
    emit(enc_r(5'd0, 5'd1, 5'd2));
    emit(enc_i(opc_load, 5'd0, 3'b011, 5'd0, 12'h040));
    emit(enc_r(5'd1, 5'd0, 5'd0));
    emit(enc_i(opc_addi, 5'd2, 3'd0, 5'd0, 12'd0));
    emit(enc_r(5'd3, 5'd0, 5'd4));
    run_test("x0");

    new_program();
    emit(enc_i(opc_fence, 5'd0, 3'd0, 5'd0, 12'd0));
    emit(enc_i(opc_addi, 5'd1, 3'd0, 5'd0, 12'(rand_bits(12))));
    run_test("halt");

    $display("tests passed %0d failed %0d", chk_i.n_pass, chk_i.n_fail);
    if (chk_i.n_fail == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  core_top #(.reset_pc(reset_pc)) dut_i (
    .clk, .rst, .start, .imem_addr, .imem_rdata, .mem_out, .mem_rdata, .retire_out, .halted
  );

  tb_checker #(.reset_pc(reset_pc)) chk_i (.*);

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the core testbench with verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f all.f --top-module tb_top -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1

/* verilog/core_fsm.sv */
// run control
module core_fsm (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic ecall_seen,
  output logic count_en,
  output logic halted
);

  typedef enum logic [1:0] {st_idle, st_run, st_halted} state_t;

  state_t state;
  state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (start) state_next = st_run;
      end
      st_run: begin
        if (ecall_seen) state_next = st_halted;
      end
      // only reset leaves halted
      default: state_next = st_halted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  assign count_en = (state == st_run);
  assign halted   = (state == st_halted);

endmodule

/* verilog/core_pkg.sv */
// core shared definitions
package core_pkg;

  parameter int xlen = 64;

  // instruction cycle, zero while the core is stopped
  typedef logic [2:0] slot_t;

  localparam slot_t slot_fetch = 3'd1;
  localparam slot_t slot_ir    = 3'd2;
  localparam slot_t slot_dec0  = 3'd3;
  localparam slot_t slot_dec1  = 3'd4;
  localparam slot_t slot_exec  = 3'd5;
  localparam slot_t slot_wb    = 3'd6;

  typedef enum logic [2:0] {r, i, s, b, u, j, none} inst_type_t;

  // major opcodes, instruction bits 6:2
  localparam logic [4:0] opc_lui   = 5'b01101;
  localparam logic [4:0] opc_auipc = 5'b00101;
  localparam logic [4:0] opc_jal   = 5'b11011;
  localparam logic [4:0] opc_jalr  = 5'b11001;
  localparam logic [4:0] opc_beq   = 5'b11000;
  localparam logic [4:0] opc_load  = 5'b00000;
  localparam logic [4:0] opc_store = 5'b01000;
  localparam logic [4:0] opc_addi  = 5'b00100;
  localparam logic [4:0] opc_add   = 5'b01100;
  localparam logic [4:0] opc_fence = 5'b00011;
  localparam logic [4:0] opc_env   = 5'b11100;

  // store widths
  localparam logic [2:0] funct3_sb = 3'b000;
  localparam logic [2:0] funct3_sh = 3'b001;
  localparam logic [2:0] funct3_sw = 3'b010;
  localparam logic [2:0] funct3_sd = 3'b011;

  typedef struct packed {
    logic            ren;
    logic            wen;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] wmask;
  } mem_req_t;

  typedef struct packed {
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [xlen-1:0] t1;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [4:0]      opcode;
    logic [2:0]      funct3;
    mem_req_t        mem;
  } dec_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic            rd_wen;
    logic [xlen-1:0] data;
  } retire_t;

endpackage

/* verilog/core_top.sv */
// multi-cycle rv64i core
module core_top import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  output logic [xlen-1:0] imem_addr,
  input  logic [31:0]     imem_rdata,
  output mem_req_t        mem_out,
  input  logic [xlen-1:0] mem_rdata,
  output retire_t         retire_out,
  output logic            halted
);

  logic            count_en;
  logic            ecall_seen;
  slot_t           slot;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] next_pc;
  logic [31:0]     inst;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  dec_t            dec;
  logic            rf_wen;
  logic [4:0]      rf_rd;
  logic [xlen-1:0] rf_data;

  core_fsm fsm_i (
    .clk, .rst, .start, .ecall_seen, .count_en, .halted
  );

  cycle_counter counter_i (
    .clk, .rst, .count_en, .slot
  );

  if_stage #(.reset_pc(reset_pc)) if_i (
    .clk, .rst, .slot, .next_pc, .imem_rdata, .imem_addr, .pc, .inst
  );

  id_stage id_i (
    .clk, .rst, .slot, .inst, .pc, .rs1_data, .rs2_data, .rs1, .rs2, .dec
  );

  regfile rf_i (
    .clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data,
    .wen(rf_wen), .rd(rf_rd), .rd_data(rf_data)
  );

  ex_stage ex_i (
    .clk, .rst, .slot, .dec, .pc, .mem_rdata, .mem_out, .next_pc,
    .rf_wen, .rf_rd, .rf_data, .retire_out, .ecall_seen
  );

endmodule

/* verilog/cycle_counter.sv */
// instruction cycle counter
module cycle_counter import core_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  count_en,
  output slot_t slot
);

  slot_t slot_next;

  // 1..6 while running, wraps back to fetch
  always_comb begin
    if (!count_en) begin
      slot_next = '0;
    end else if (slot == slot_wb || slot == '0) begin
      slot_next = slot_fetch;
    end else begin
      slot_next = slot + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot <= '0;
    end else begin
      slot <= slot_next;
    end
  end

endmodule

/* verilog/ex_stage.sv */
// execute and writeback
module ex_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  slot_t           slot,
  input  dec_t            dec,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] mem_rdata,
  output mem_req_t        mem_out,
  output logic [xlen-1:0] next_pc,
  output logic            rf_wen,
  output logic [4:0]      rf_rd,
  output logic [xlen-1:0] rf_data,
  output retire_t         retire_out,
  output logic            ecall_seen
);

  logic            is_wb;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] result_d;
  logic [xlen-1:0] next_pc_d;
  logic [xlen-1:0] result_q;
  mem_req_t        mem_q;
  logic [4:0]      rd_q;
  logic            rd_wen_q;
  logic            env_q;

  assign is_wb    = (slot == slot_wb);
  assign pc_plus4 = pc + 64'd4;

  always_comb begin
    result_d  = dec.op1 + dec.op2;
    next_pc_d = pc_plus4;
    case (dec.opcode)
      opc_jal: begin
        result_d  = dec.op1;
        next_pc_d = dec.op2;
      end
      opc_jalr: begin
        result_d  = dec.t1;
        next_pc_d = {dec.mem.addr[xlen-1:1], 1'b0};
      end
      opc_beq: begin
        if (dec.op1 == dec.op2) next_pc_d = dec.t1;
      end
      default: ;
    endcase
  end

  // decode drops its enables after slot 4, so keep a copy here
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q.ren <= 1'b0;
      mem_q.wen <= 1'b0;
      rd_wen_q  <= 1'b0;
      env_q     <= 1'b0;
    end else if (slot == slot_exec) begin
      result_q <= result_d;
      next_pc  <= next_pc_d;
      mem_q    <= dec.mem;
      rd_q     <= dec.rd;
      rd_wen_q <= dec.rd_wen;
      env_q    <= (dec.opcode == opc_env);
    end
  end

  // memory strobes only in slot 6
  always_comb begin
    mem_out     = mem_q;
    mem_out.ren = is_wb && mem_q.ren;
    mem_out.wen = is_wb && mem_q.wen;
  end

  assign rf_wen  = is_wb && rd_wen_q;
  assign rf_rd   = rd_q;
  assign rf_data = mem_q.ren ? mem_rdata : result_q;

  assign retire_out.valid  = is_wb;
  assign retire_out.pc     = pc;
  assign retire_out.rd     = rd_q;
  assign retire_out.rd_wen = rd_wen_q;
  assign retire_out.data   = rf_data;

  assign ecall_seen = is_wb && env_q;

endmodule

/* verilog/id_stage.sv */
// decode stage
module id_stage import core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  slot_t           slot,
  input  logic [31:0]     inst,
  input  logic [xlen-1:0] pc,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output dec_t            dec
);

  logic            id_active;
  logic [4:0]      opcode;
  logic [2:0]      funct3;
  inst_type_t      inst_type;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_imm;
  dec_t            dec_next;

  // decode works in slots 3 and 4 only
  assign id_active = (slot == slot_dec0) || (slot == slot_dec1);

  assign opcode   = inst[6:2];
  assign funct3   = inst[14:12];
  assign rs1      = id_active ? inst[19:15] : 5'd0;
  assign rs2      = id_active ? inst[24:20] : 5'd0;
  assign pc_plus4 = pc + 64'd4;
  assign pc_imm   = pc + imm;

  always_comb begin
    case (opcode)
      opc_lui, opc_auipc: inst_type = u;
      opc_jal:            inst_type = j;
      opc_beq:            inst_type = b;
      opc_store:          inst_type = s;
      opc_add:            inst_type = r;
      opc_jalr, opc_load, opc_addi, opc_fence, opc_env: inst_type = i;
      default:            inst_type = none;
    endcase
  end

  // sign-extended immediate per format
  always_comb begin
    case (inst_type)
      i: imm = {{52{inst[31]}}, inst[31:20]};
      s: imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      b: imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      u: imm = {{32{inst[31]}}, inst[31:12], 12'b0};
      j: imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    dec_next        = '0;
    dec_next.rd     = inst[11:7];
    dec_next.opcode = opcode;
    dec_next.funct3 = funct3;

    case (inst_type)
      r, b: begin
        dec_next.op1 = rs1_data;
        dec_next.op2 = rs2_data;
      end
      i: begin
        dec_next.op1 = rs1_data;
        dec_next.op2 = imm;
      end
      // link value and jump target
      j: begin
        dec_next.op1 = pc_plus4;
        dec_next.op2 = pc_imm;
      end
      u: begin
        dec_next.op1 = (opcode == opc_auipc) ? pc : '0;
        dec_next.op2 = imm;
      end
      default: ;
    endcase

    if (opcode == opc_jalr) begin
      dec_next.t1 = pc_plus4;
    end else if (opcode == opc_beq) begin
      dec_next.t1 = pc_imm;
    end

    dec_next.rd_wen = (inst_type == r || inst_type == i || inst_type == u || inst_type == j)
                      && opcode != opc_fence && opcode != opc_env;

    // mask always covers the low bytes
    dec_next.mem.ren   = (opcode == opc_load);
    dec_next.mem.wen   = (inst_type == s);
    dec_next.mem.addr  = rs1_data + imm;
    dec_next.mem.wdata = rs2_data;
    if (inst_type == s) begin
      case (funct3)
        funct3_sb: dec_next.mem.wmask = 64'h0000_0000_0000_00ff;
        funct3_sh: dec_next.mem.wmask = 64'h0000_0000_0000_ffff;
        funct3_sw: dec_next.mem.wmask = 64'h0000_0000_ffff_ffff;
        funct3_sd: dec_next.mem.wmask = 64'hffff_ffff_ffff_ffff;
        default:   dec_next.mem.wmask = '0;
      endcase
    end
  end

  // second load in slot 4 picks up settled register data
  always_ff @(posedge clk) begin
    if (rst || !id_active) begin
      dec.rd_wen  <= 1'b0;
      dec.mem.ren <= 1'b0;
      dec.mem.wen <= 1'b0;
    end else begin
      dec <= dec_next;
    end
  end

endmodule

/* verilog/if_stage.sv */
// fetch stage
module if_stage import core_pkg::*; #(
  parameter logic [xlen-1:0] reset_pc = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  slot_t           slot,
  input  logic [xlen-1:0] next_pc,
  input  logic [31:0]     imem_rdata,
  output logic [xlen-1:0] imem_addr,
  output logic [xlen-1:0] pc,
  output logic [31:0]     inst
);

  // pc moves once per instruction, at the end of writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else if (slot == slot_wb) begin
      pc <= next_pc;
    end
  end

  // rom answers in the same cycle
  always_ff @(posedge clk) begin
    if (slot == slot_ir) begin
      inst <= imem_rdata;
    end
  end

  assign imem_addr = pc;

endmodule

/* verilog/regfile.sv */
// integer register file
module regfile import core_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1,
  input  logic [4:0]      rs2,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data,
  input  logic            wen,
  input  logic [4:0]      rd,
  input  logic [xlen-1:0] rd_data
);

  logic [xlen-1:0] regs [32];

  // x0 never written
  always_ff @(posedge clk) begin
    if (!rst && wen && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule
